// File: lsu_pkg.sv
/*
 * Shared definitions for the load/store data-memory subsystem
 * Bus widths and counter width
 * Access size, controller state and counter select enums
 * Core request, memory request and load info packed structs
 */

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  // One enable per byte lane
  localparam int unsigned BE_W   = DATA_W / 8;
  localparam int unsigned CNT_W  = 16;

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  // Access size, same encoding as the core decoder
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

  // Load/store controller states
  typedef enum logic [1:0] {
    LSU_IDLE        = 2'b00,
    LSU_WAIT_GNT    = 2'b01,
    LSU_WAIT_RVALID = 2'b10
  } lsu_state_e;

  // Event counter read select
  typedef enum logic {
    CNT_LOAD  = 1'b0,
    CNT_STORE = 1'b1
  } cnt_sel_e;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // Core side request, byte address and unshifted data
  typedef struct packed {
    logic              we;
    data_type_e        data_type;
    logic              sign_ext;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } lsu_req_t;

  // Memory port request, word address and lane aligned data
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  // Kept for the pending load until rvalid
  typedef struct packed {
    logic [1:0] offset;
    data_type_e data_type;
    logic       sign_ext;
  } load_info_t;

endpackage

// File: lsu_req_align.sv
/*
 * Request alignment for the data memory port
 * Word address, byte enables and write data lane rotation
 * Misaligned half and word detection
 */

`timescale 1ns/1ps

module lsu_req_align import lsu_pkg::*; (
  input  lsu_req_t lsu_req_i,
  output mem_req_t mem_req_o,
  output logic     misaligned_o
);

  logic [1:0] offset;

  // Byte offset inside the addressed word
  assign offset = lsu_req_i.addr[1:0];

  assign mem_req_o.addr = {lsu_req_i.addr[ADDR_W-1:2], 2'b00};
  assign mem_req_o.we   = lsu_req_i.we;

  ////////////////////////////////////////////////////////////
  // Byte enables and misalignment
  ////////////////////////////////////////////////////////////

  always_comb begin
    mem_req_o.be = '1;
    misaligned_o = 1'b0;
    case (lsu_req_i.data_type)
      DT_BYTE: begin
        mem_req_o.be = 4'b0001 << offset;
      end
      DT_HALF: begin
        // Upper or lower half, odd address is illegal
        mem_req_o.be = offset[1] ? 4'b1100 : 4'b0011;
        misaligned_o = offset[0];
      end
      default: begin
        // Word, and the unused encoding treated as word
        mem_req_o.be = 4'b1111;
        misaligned_o = (offset != 2'b00);
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Write data rotation into the addressed lanes
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (offset)
      2'b00:   mem_req_o.wdata = lsu_req_i.wdata;
      2'b01:   mem_req_o.wdata = {lsu_req_i.wdata[23:0], lsu_req_i.wdata[31:24]};
      2'b10:   mem_req_o.wdata = {lsu_req_i.wdata[15:0], lsu_req_i.wdata[31:16]};
      default: mem_req_o.wdata = {lsu_req_i.wdata[7:0], lsu_req_i.wdata[31:8]};
    endcase
  end

endmodule

// File: lsu_load_extract.sv
/*
 * Load data extraction
 * Lane selection by byte offset, sign or zero extension
 */

`timescale 1ns/1ps

module lsu_load_extract import lsu_pkg::*; (
  input  logic [DATA_W-1:0] rdata_i,
  input  load_info_t        info_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] rdata_shift;

  // Rotate the addressed lane down to bit 0
  always_comb begin
    case (info_i.offset)
      2'b00:   rdata_shift = rdata_i;
      2'b01:   rdata_shift = {rdata_i[7:0], rdata_i[31:8]};
      2'b10:   rdata_shift = {rdata_i[15:0], rdata_i[31:16]};
      default: rdata_shift = {rdata_i[23:0], rdata_i[31:24]};
    endcase
  end

  // Extension by size and flag
  always_comb begin
    case (info_i.data_type)
      DT_BYTE: begin
        rdata_o = {{24{info_i.sign_ext & rdata_shift[7]}}, rdata_shift[7:0]};
      end
      DT_HALF: begin
        rdata_o = {{16{info_i.sign_ext & rdata_shift[15]}}, rdata_shift[15:0]};
      end
      default: begin
        // Word loads are always aligned
        rdata_o = rdata_i;
      end
    endcase
  end

endmodule

// File: lsu_ctrl.sv
/*
 * Load/store controller
 * FSM for request, grant and response phases
 * Registered memory request and load info, error pulse on misalignment
 */

`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
  input  logic              clk,
  input  logic              rst_ni,
  // Core side
  input  logic              lsu_req_valid_i,
  input  lsu_req_t          lsu_req_i,
  // Memory side
  output logic              mem_req_valid_o,
  output mem_req_t          mem_req_o,
  input  logic              mem_gnt_i,
  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i,
  // Completion
  output logic              lsu_valid_o,
  output logic              lsu_err_o,
  output logic [DATA_W-1:0] lsu_rdata_o,
  output logic              busy_o
);

  lsu_state_e state_q;
  lsu_state_e state_d;
  mem_req_t   aligned_req;
  mem_req_t   mem_req_q;
  load_info_t info_q;
  logic       misaligned;
  logic       accept;
  logic       err_q;

  lsu_req_align i_req_align (
    .lsu_req_i    ( lsu_req_i   ),
    .mem_req_o    ( aligned_req ),
    .misaligned_o ( misaligned  )
  );

  // New requests only taken in idle
  assign accept = lsu_req_valid_i & (state_q == LSU_IDLE);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      LSU_IDLE: begin
        if (accept && !misaligned) begin
          state_d = LSU_WAIT_GNT;
        end
      end
      LSU_WAIT_GNT: begin
        if (mem_gnt_i) begin
          state_d = LSU_WAIT_RVALID;
        end
      end
      LSU_WAIT_RVALID: begin
        if (mem_rvalid_i) begin
          state_d = LSU_IDLE;
        end
      end
      default: state_d = LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LSU_IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // One cycle error pulse, request is dropped
      err_q   <= accept & misaligned;
    end
  end

  // Request fields held stable until the grant
  always_ff @(posedge clk) begin
    if (accept) begin
      mem_req_q        <= aligned_req;
      info_q.offset    <= lsu_req_i.addr[1:0];
      info_q.data_type <= lsu_req_i.data_type;
      info_q.sign_ext  <= lsu_req_i.sign_ext;
    end
  end

  lsu_load_extract i_load_extract (
    .rdata_i ( mem_rdata_i ),
    .info_i  ( info_q      ),
    .rdata_o ( lsu_rdata_o )
  );

  assign mem_req_valid_o = (state_q == LSU_WAIT_GNT);
  assign mem_req_o       = mem_req_q;
  // Completion in the rvalid cycle itself
  assign lsu_valid_o     = (state_q == LSU_WAIT_RVALID) & mem_rvalid_i;
  assign lsu_err_o       = err_q;
  assign busy_o          = (state_q != LSU_IDLE);

endmodule

// File: data_mem_arbiter.sv
/*
 * Data port arbiter between the core path and the debug port
 * Debug first selection, single outstanding transaction
 * Response steering to the recorded owner
 */

`timescale 1ns/1ps

module data_mem_arbiter import lsu_pkg::*; (
  input  logic              clk,
  input  logic              rst_ni,
  // Core side
  input  logic              core_req_i,
  input  mem_req_t          core_mem_i,
  output logic              core_gnt_o,
  output logic              core_rvalid_o,
  output logic [DATA_W-1:0] core_rdata_o,
  // Debug side
  input  logic              dbg_req_i,
  input  mem_req_t          dbg_mem_i,
  output logic              dbg_gnt_o,
  output logic              dbg_rvalid_o,
  output logic [DATA_W-1:0] dbg_rdata_o,
  // Memory side
  output logic              data_req_o,
  output mem_req_t          data_mem_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic [DATA_W-1:0] data_rdata_i,
  // Status
  output logic              pending_o
);

  logic pending_q;
  logic owner_dbg_q;
  logic granted;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Nothing forwarded while a response is outstanding
  assign data_req_o = ~pending_q & (dbg_req_i | core_req_i);
  assign data_mem_o = dbg_req_i ? dbg_mem_i : core_mem_i;

  assign dbg_gnt_o  = ~pending_q & dbg_req_i & data_gnt_i;
  assign core_gnt_o = ~pending_q & ~dbg_req_i & core_req_i & data_gnt_i;
  assign granted    = data_req_o & data_gnt_i;

  // Owner recorded at the granting edge
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q   <= 1'b0;
      owner_dbg_q <= 1'b0;
    end else if (granted) begin
      pending_q   <= 1'b1;
      owner_dbg_q <= dbg_req_i;
    end else if (data_rvalid_i) begin
      pending_q   <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  assign core_rvalid_o = data_rvalid_i & pending_q & ~owner_dbg_q;
  assign dbg_rvalid_o  = data_rvalid_i & pending_q & owner_dbg_q;
  assign core_rdata_o  = owner_dbg_q ? '0 : data_rdata_i;
  assign dbg_rdata_o   = owner_dbg_q ? data_rdata_i : '0;

  assign pending_o = pending_q;

endmodule

// File: mem_event_counters.sv
/*
 * Load and store event counters
 * Saturating counts of granted core requests, select based read port
 */

`timescale 1ns/1ps

module mem_event_counters import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rst_ni,
  input  logic             gnt_event_i,
  input  logic             gnt_we_i,
  input  cnt_sel_e         cnt_sel_i,
  output logic [CNT_W-1:0] cnt_rdata_o
);

  logic [CNT_W-1:0] load_cnt_q;
  logic [CNT_W-1:0] store_cnt_q;

  // Counts stop at all ones
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      load_cnt_q  <= '0;
      store_cnt_q <= '0;
    end else if (gnt_event_i) begin
      if (!gnt_we_i && (load_cnt_q != {CNT_W{1'b1}})) begin
        load_cnt_q <= load_cnt_q + 1'b1;
      end
      if (gnt_we_i && (store_cnt_q != {CNT_W{1'b1}})) begin
        store_cnt_q <= store_cnt_q + 1'b1;
      end
    end
  end

  // Combinational read port
  assign cnt_rdata_o = (cnt_sel_i == CNT_STORE) ? store_cnt_q : load_cnt_q;

endmodule

// File: lsu_subsys_top.sv
/*
 * Top level of the data-memory subsystem
 * Load/store controller, data port arbiter and event counters
 */

`timescale 1ns/1ps

module lsu_subsys_top import lsu_pkg::*; (
  input  logic              clk,
  input  logic              rst_ni,
  // Core side
  input  logic              lsu_req_valid_i,
  input  lsu_req_t          lsu_req_i,
  output logic              lsu_valid_o,
  output logic              lsu_err_o,
  output logic [DATA_W-1:0] lsu_rdata_o,
  // Debug side
  input  logic              dbg_req_i,
  input  mem_req_t          dbg_mem_i,
  output logic              dbg_gnt_o,
  output logic              dbg_rvalid_o,
  output logic [DATA_W-1:0] dbg_rdata_o,
  // Memory side
  output logic              data_req_o,
  output mem_req_t          data_mem_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic [DATA_W-1:0] data_rdata_i,
  // Counters and status
  input  cnt_sel_e          cnt_sel_i,
  output logic [CNT_W-1:0]  cnt_rdata_o,
  output logic              busy_o
);

  // Core path between controller and arbiter
  logic              core_req;
  mem_req_t          core_mem;
  logic              core_gnt;
  logic              core_rvalid;
  logic [DATA_W-1:0] core_rdata;
  logic              ctrl_busy;
  logic              arb_pending;

  lsu_ctrl i_lsu_ctrl (
    .clk             ( clk             ),
    .rst_ni          ( rst_ni          ),
    .lsu_req_valid_i ( lsu_req_valid_i ),
    .lsu_req_i       ( lsu_req_i       ),
    .mem_req_valid_o ( core_req        ),
    .mem_req_o       ( core_mem        ),
    .mem_gnt_i       ( core_gnt        ),
    .mem_rvalid_i    ( core_rvalid     ),
    .mem_rdata_i     ( core_rdata      ),
    .lsu_valid_o     ( lsu_valid_o     ),
    .lsu_err_o       ( lsu_err_o       ),
    .lsu_rdata_o     ( lsu_rdata_o     ),
    .busy_o          ( ctrl_busy       )
  );

  data_mem_arbiter i_arbiter (
    .clk           ( clk           ),
    .rst_ni        ( rst_ni        ),
    .core_req_i    ( core_req      ),
    .core_mem_i    ( core_mem      ),
    .core_gnt_o    ( core_gnt      ),
    .core_rvalid_o ( core_rvalid   ),
    .core_rdata_o  ( core_rdata    ),
    .dbg_req_i     ( dbg_req_i     ),
    .dbg_mem_i     ( dbg_mem_i     ),
    .dbg_gnt_o     ( dbg_gnt_o     ),
    .dbg_rvalid_o  ( dbg_rvalid_o  ),
    .dbg_rdata_o   ( dbg_rdata_o   ),
    .data_req_o    ( data_req_o    ),
    .data_mem_o    ( data_mem_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_rdata_i  ( data_rdata_i  ),
    .pending_o     ( arb_pending   )
  );

  // Only granted core requests are counted
  mem_event_counters i_counters (
    .clk         ( clk                  ),
    .rst_ni      ( rst_ni               ),
    .gnt_event_i ( core_req & core_gnt  ),
    .gnt_we_i    ( core_mem.we          ),
    .cnt_sel_i   ( cnt_sel_i            ),
    .cnt_rdata_o ( cnt_rdata_o          )
  );

  assign busy_o = ctrl_busy | arb_pending;

endmodule

// File: tb_lsu_subsys.sv
/*
 * Testbench for the data-memory subsystem
 * Stimulus table with expected error flags, applied in a loop
 * Memory model with random grant delay, debug port driver
 * Value check task, per-test report and cycle timeout
 */

`timescale 1ns/1ps

module tb_lsu_subsys import lsu_pkg::*; ();

  localparam int unsigned DRIVE_DLY = 10;
  localparam int unsigned MEM_WORDS = 256;
  localparam logic [31:0] DBG_ADDR  = 32'h0000_0104;

  logic              clk;
  logic              rst_ni;
  logic              lsu_req_valid_i;
  lsu_req_t          lsu_req_i;
  logic              lsu_valid_o;
  logic              lsu_err_o;
  logic [DATA_W-1:0] lsu_rdata_o;
  logic              dbg_req_i;
  mem_req_t          dbg_mem_i;
  logic              dbg_gnt_o;
  logic              dbg_rvalid_o;
  logic [DATA_W-1:0] dbg_rdata_o;
  logic              data_req_o;
  mem_req_t          data_mem_o;
  logic              data_gnt_i;
  logic              data_rvalid_i;
  logic [DATA_W-1:0] data_rdata_i;
  cnt_sel_e          cnt_sel_i;
  logic [CNT_W-1:0]  cnt_rdata_o;
  logic              busy_o;

  // Stimulus table, one entry per test
  string       row_name[$];
  lsu_req_t    row_req[$];
  bit          row_dbg[$];
  bit          row_err[$];

  // Memory contents seen by the DUT, and the expected contents
  logic [31:0] mem_array [MEM_WORDS];
  logic [31:0] ref_mem   [MEM_WORDS];

  string       cur_name;
  int          err_count;
  int          test_count;
  int          failed_tests;
  int          cycle_count;
  int          cycle_limit;

  lsu_subsys_top i_dut (
    .clk, .rst_ni, .lsu_req_valid_i, .lsu_req_i, .lsu_valid_o, .lsu_err_o, .lsu_rdata_o,
    .dbg_req_i, .dbg_mem_i, .dbg_gnt_o, .dbg_rvalid_o, .dbg_rdata_o,
    .data_req_o, .data_mem_o, .data_gnt_i, .data_rvalid_i, .data_rdata_i,
    .cnt_sel_i, .cnt_rdata_o, .busy_o
  );

  always #50 clk = ~clk;

  // Run limit from the table length
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles in test %s", cycle_count, cur_name);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error: %s %s expected %h actual %h", cur_name, what, expected, actual);
      err_count++;
    end
  endtask

  task automatic add_row(input string name, input logic we, input data_type_e dt,
                         input logic sext, input logic [31:0] addr,
                         input logic [31:0] wdata, input bit dbg, input bit err);
    lsu_req_t req;
    req.we        = we;
    req.data_type = dt;
    req.sign_ext  = sext;
    req.addr      = addr;
    req.wdata     = wdata;
    row_name.push_back(name);
    row_req.push_back(req);
    row_dbg.push_back(dbg);
    row_err.push_back(err);
  endtask

  // Preload pattern over the full byte address of each word
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
  endfunction

  function automatic int size_bytes(input data_type_e dt);
    if (dt == DT_BYTE) return 1;
    if (dt == DT_HALF) return 2;
    return 4;
  endfunction

  // Enables cover the access size starting at the byte offset
  function automatic logic [3:0] expect_be(input lsu_req_t r);
    logic [7:0] mask;
    mask = ((8'd1 << size_bytes(r.data_type)) - 8'd1) << r.addr[1:0];
    return mask[3:0];
  endfunction

  // Store data moved up by the byte offset, wrapping around
  function automatic logic [31:0] expect_wdata(input lsu_req_t r);
    int sh;
    sh = 8 * r.addr[1:0];
    return (r.wdata << sh) | (r.wdata >> (32 - sh));
  endfunction

  function automatic logic [31:0] expect_load(input lsu_req_t r);
    logic [31:0] word;
    word = ref_mem[r.addr[9:2]] >> (8 * r.addr[1:0]);
    if (r.data_type == DT_BYTE) return {{24{r.sign_ext & word[7]}}, word[7:0]};
    if (r.data_type == DT_HALF) return {{16{r.sign_ext & word[15]}}, word[15:0]};
    return ref_mem[r.addr[9:2]];
  endfunction

  task automatic update_ref(input lsu_req_t r);
    logic [3:0]  be;
    logic [31:0] wd;
    int          lane;
    be = expect_be(r);
    wd = expect_wdata(r);
    for (lane = 0; lane < 4; lane++) begin
      if (be[lane]) ref_mem[r.addr[9:2]][8*lane +: 8] = wd[8*lane +: 8];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////

  initial begin : memory_model
    mem_req_t held;
    int       delay;
    int       lane;
    void'($urandom(29131));
    forever begin
      @(negedge clk);
      if (rst_ni && data_req_o === 1'b1) begin
        held  = data_mem_o;
        delay = $urandom % 4;
        // Request must hold while grant is withheld
        repeat (delay + 1) begin
          if (delay > 0) @(negedge clk);
          if (data_req_o !== 1'b1 || data_mem_o !== held) begin
            $display("memory request dropped or changed before grant in test %s", cur_name);
            err_count++;
          end
          delay--;
        end
        @(posedge clk);
        #DRIVE_DLY;
        data_gnt_i = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        data_gnt_i = 1'b0;
        for (lane = 0; lane < 4; lane++) begin
          if (held.we && held.be[lane]) begin
            mem_array[held.addr[9:2]][8*lane +: 8] = held.wdata[8*lane +: 8];
          end
        end
        data_rdata_i  = held.we ? '0 : mem_array[held.addr[9:2]];
        data_rvalid_i = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        data_rvalid_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // One table row
  ////////////////////////////////////////////////////////////

  task automatic run_row(input int idx);
    lsu_req_t    req;
    mem_req_t    seen;
    logic [31:0] got_data;
    bit          core_seen;
    bit          dbg_finished;
    req          = row_req[idx];
    cur_name     = row_name[idx];
    core_seen    = 1'b0;
    dbg_finished = 1'b0;
    check_value("busy before request", 0, busy_o);
    lsu_req_valid_i = 1'b1;
    lsu_req_i       = req;
    @(posedge clk);
    #DRIVE_DLY;
    lsu_req_valid_i = 1'b0;
    if (row_dbg[idx]) begin
      dbg_req_i       = 1'b1;
      dbg_mem_i.addr  = DBG_ADDR;
      dbg_mem_i.we    = 1'b0;
      dbg_mem_i.be    = 4'hF;
      dbg_mem_i.wdata = '0;
    end
    @(negedge clk);
    check_value("error flag", row_err[idx], lsu_err_o);
    check_value("memory request", !row_err[idx], data_req_o);
    if (row_err[idx]) begin
      @(negedge clk);
      check_value("error pulse end", 0, lsu_err_o);
      check_value("memory request", 0, data_req_o);
      check_value("valid", 0, lsu_valid_o);
    end else begin
      fork
        begin
          while (lsu_valid_o !== 1'b1) begin
            // A grant that does not go to the debug side belongs to the core
            if (data_req_o === 1'b1 && data_gnt_i && dbg_gnt_o !== 1'b1) begin
              seen      = data_mem_o;
              core_seen = 1'b1;
            end
            @(negedge clk);
          end
          got_data = lsu_rdata_o;
          if (row_dbg[idx]) check_value("debug done before core", 1, dbg_finished);
          @(negedge clk);
          check_value("valid pulse end", 0, lsu_valid_o);
        end
        begin
          if (row_dbg[idx]) begin
            while (dbg_gnt_o !== 1'b1) @(negedge clk);
            check_value("debug granted first", 0, core_seen);
            @(posedge clk);
            #DRIVE_DLY;
            dbg_req_i = 1'b0;
            while (dbg_rvalid_o !== 1'b1) @(negedge clk);
            check_value("debug read data", ref_mem[DBG_ADDR[9:2]], dbg_rdata_o);
            dbg_finished = 1'b1;
          end
        end
      join
      if (!core_seen) begin
        $display("no grant of the core request was seen in test %s", cur_name);
        err_count++;
      end else begin
        check_value("address", {req.addr[31:2], 2'b00}, seen.addr);
        check_value("write enable", req.we, seen.we);
        check_value("byte enables", expect_be(req), seen.be);
        if (req.we) begin
          check_value("write data", expect_wdata(req), seen.wdata);
          update_ref(req);
        end else begin
          check_value("load data", expect_load(req), got_data);
        end
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic report_test(input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("test %s: ok", cur_name);
    end else begin
      $display("test %s: failed", cur_name);
      failed_tests++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int exp_loads;
    int exp_stores;
    int errs_before;
    int i;
    clk = 1'b0;
    rst_ni = 1'b0;
    lsu_req_valid_i = 1'b0;
    lsu_req_i = '0;
    dbg_req_i = 1'b0;
    dbg_mem_i = '0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
    cnt_sel_i = CNT_LOAD;
    err_count = 0;
    test_count = 0;
    failed_tests = 0;
    cycle_count = 0;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem_array[i] = fill_word(i * 4);
      ref_mem[i]   = fill_word(i * 4);
    end
    //      name          we    size     sext  addr          wdata         dbg  err
    add_row("sw_word",    1'b1, DT_WORD, 1'b0, 32'h0000_0100, 32'hDEAD_BEEF, 0, 0);
    add_row("lw_word",    1'b0, DT_WORD, 1'b0, 32'h0000_0100, 32'h0,        0, 0);
    add_row("sb_off1",    1'b1, DT_BYTE, 1'b0, 32'h0000_0105, 32'h0000_00F1, 0, 0);
    add_row("lb_sext",    1'b0, DT_BYTE, 1'b1, 32'h0000_0105, 32'h0,        0, 0);
    add_row("lbu_zext",   1'b0, DT_BYTE, 1'b0, 32'h0000_0105, 32'h0,        0, 0);
    add_row("sh_upper",   1'b1, DT_HALF, 1'b0, 32'h0000_010A, 32'h0000_8421, 0, 0);
    add_row("lh_sext",    1'b0, DT_HALF, 1'b1, 32'h0000_010A, 32'h0,        0, 0);
    add_row("lhu_zext",   1'b0, DT_HALF, 1'b0, 32'h0000_010A, 32'h0,        0, 0);
    add_row("lb_pattern", 1'b0, DT_BYTE, 1'b1, 32'h0000_0203, 32'h0,        0, 0);
    add_row("sh_misal",   1'b1, DT_HALF, 1'b0, 32'h0000_0111, 32'h0000_1234, 0, 1);
    add_row("lw_misal",   1'b0, DT_WORD, 1'b0, 32'h0000_0122, 32'h0,        0, 1);
    add_row("lw_dbg",     1'b0, DT_WORD, 1'b0, 32'h0000_0100, 32'h0,        1, 0);
    add_row("sw_dbg",     1'b1, DT_WORD, 1'b0, 32'h0000_0180, 32'h1357_9BDF, 1, 0);
    add_row("lw_after",   1'b0, DT_WORD, 1'b0, 32'h0000_0180, 32'h0,        0, 0);
    cycle_limit = row_name.size() * 10 + 50;
    exp_loads  = 0;
    exp_stores = 0;
    foreach (row_req[k]) begin
      if (!row_err[k] && row_req[k].we) exp_stores++;
      if (!row_err[k] && !row_req[k].we) exp_loads++;
    end

    // Reset for 3 cycles, then check the idle outputs
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst_ni = 1'b1;
    cur_name = "reset";
    errs_before = err_count;
    check_value("data_req_o", 0, data_req_o);
    check_value("lsu_valid_o", 0, lsu_valid_o);
    check_value("lsu_err_o", 0, lsu_err_o);
    check_value("dbg_gnt_o", 0, dbg_gnt_o);
    check_value("dbg_rvalid_o", 0, dbg_rvalid_o);
    check_value("busy_o", 0, busy_o);
    check_value("load count", 0, cnt_rdata_o);
    cnt_sel_i = CNT_STORE;
    @(negedge clk);
    check_value("store count", 0, cnt_rdata_o);
    @(posedge clk);
    #DRIVE_DLY;
    cnt_sel_i = CNT_LOAD;
    report_test(errs_before);

    for (i = 0; i < row_name.size(); i++) begin
      errs_before = err_count;
      run_row(i);
      report_test(errs_before);
    end

    // Debug accesses must not show up in the counts
    cur_name = "counters";
    errs_before = err_count;
    check_value("busy after last completion", 0, busy_o);
    cnt_sel_i = CNT_LOAD;
    @(negedge clk);
    check_value("load count", exp_loads, cnt_rdata_o);
    @(posedge clk);
    #DRIVE_DLY;
    cnt_sel_i = CNT_STORE;
    @(negedge clk);
    check_value("store count", exp_stores, cnt_rdata_o);
    report_test(errs_before);

    $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: lsu_subsys.f
lsu_pkg.sv
lsu_req_align.sv
lsu_load_extract.sv
lsu_ctrl.sv
data_mem_arbiter.sv
mem_event_counters.sv
lsu_subsys_top.sv
tb_lsu_subsys.sv

// File: Bender.yml
package:
  name: lsu_subsys

sources:
  - lsu_pkg.sv
  - lsu_req_align.sv
  - lsu_load_extract.sv
  - lsu_ctrl.sv
  - data_mem_arbiter.sv
  - mem_event_counters.sv
  - lsu_subsys_top.sv
  - target: test
    files:
      - tb_lsu_subsys.sv
